// File: hw/rv_pkg.sv
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int MEM_WORDS  = 1024;   // 4 KiB unified memory
    localparam int MEM_ADDR_W = 10;

    localparam logic [XLEN-1:0] UART_TX_ADDR = 32'h0002_0020;   // sb here strobes the serial port

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_idx_t;
    typedef logic [MEM_ADDR_W-1:0] mem_idx_t;
    typedef logic [7:0]            uart_byte_t;

    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B              // lui
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU
    } branch_cond_e;

    typedef enum logic [1:0] {
        JMP_SEQ,                // pc + 4
        JMP_BRANCH,             // pc + imm when taken
        JMP_JAL,
        JMP_JALR
    } jump_kind_e;

    typedef struct packed {
        reg_idx_t     rs1;
        reg_idx_t     rs2;
        reg_idx_t     rd;
        alu_op_e      alu_op;
        logic         a_sel_pc;        // operand a is pc
        logic         b_sel_imm;       // operand b is the immediate
        word_t        imm;
        branch_cond_e branch_cond;
        jump_kind_e   jump_kind;
        logic         reg_we;
        logic         mem_read;
        logic         mem_write_word;
        logic         mem_write_byte;
        logic         link;            // write back pc + 4
    } ctrl_t;

    typedef struct packed {
        mem_idx_t   idx;
        logic [3:0] be;
        word_t      wdata;
        logic       we;
    } mem_req_t;

    typedef struct packed {
        logic     en;
        mem_idx_t idx;
        word_t    data;
    } prog_load_t;

endpackage

// File: hw/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
    input  logic          i_reset,
    input  rv_pkg::word_t i_instr,
    output rv_pkg::ctrl_t o_ctrl
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    // funct3 to ALU operation, alt selects sub / sra
    function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];

    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                    i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'h000};
    assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                    i_instr[30:21], 1'b0};

    always_comb begin
        o_ctrl             = '0;        // anything not matched below is a no-op
        o_ctrl.rs1         = i_instr[19:15];
        o_ctrl.rs2         = i_instr[24:20];
        o_ctrl.rd          = i_instr[11:7];
        o_ctrl.alu_op      = ALU_ADD;
        o_ctrl.branch_cond = BR_NONE;
        o_ctrl.jump_kind   = JMP_SEQ;

        case (opcode)
            OPC_OP: begin
                if (funct7 == 7'b0000000 ||
                    (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
                    o_ctrl.alu_op = alu_from_funct3(funct3, funct7[5]);
                    o_ctrl.reg_we = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                // shift immediates need a clean funct7
                if ((funct3 != 3'b001 && funct3 != 3'b101) ||
                    (funct3 == 3'b001 && funct7 == 7'b0000000) ||
                    (funct3 == 3'b101 && (funct7 == 7'b0000000 || funct7 == 7'b0100000))) begin
                    o_ctrl.alu_op    = alu_from_funct3(funct3, funct3 == 3'b101 && funct7[5]);
                    o_ctrl.b_sel_imm = 1'b1;
                    o_ctrl.imm       = imm_i;
                    o_ctrl.reg_we    = 1'b1;
                end
            end
            OPC_LOAD: begin
                if (funct3 == 3'b010) begin       // lw only
                    o_ctrl.b_sel_imm = 1'b1;
                    o_ctrl.imm       = imm_i;
                    o_ctrl.mem_read  = 1'b1;
                    o_ctrl.reg_we    = 1'b1;
                end
            end
            OPC_STORE: begin
                o_ctrl.b_sel_imm      = 1'b1;
                o_ctrl.imm            = imm_s;
                o_ctrl.mem_write_byte = (funct3 == 3'b000);
                o_ctrl.mem_write_word = (funct3 == 3'b010);
            end
            OPC_BRANCH: begin
                o_ctrl.imm = imm_b;
                case (funct3)
                    3'b000:  o_ctrl.branch_cond = BR_EQ;
                    3'b001:  o_ctrl.branch_cond = BR_NE;
                    3'b100:  o_ctrl.branch_cond = BR_LT;
                    3'b101:  o_ctrl.branch_cond = BR_GE;
                    3'b110:  o_ctrl.branch_cond = BR_LTU;
                    3'b111:  o_ctrl.branch_cond = BR_GEU;
                    default: o_ctrl.branch_cond = BR_NONE;
                endcase
                if (o_ctrl.branch_cond != BR_NONE) begin
                    o_ctrl.jump_kind = JMP_BRANCH;
                end
            end
            OPC_JAL: begin
                o_ctrl.imm       = imm_j;
                o_ctrl.jump_kind = JMP_JAL;
                o_ctrl.link      = 1'b1;
                o_ctrl.reg_we    = 1'b1;
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    o_ctrl.imm       = imm_i;
                    o_ctrl.jump_kind = JMP_JALR;
                    o_ctrl.link      = 1'b1;
                    o_ctrl.reg_we    = 1'b1;
                end
            end
            OPC_LUI: begin
                o_ctrl.alu_op    = ALU_PASS_B;
                o_ctrl.b_sel_imm = 1'b1;
                o_ctrl.imm       = imm_u;
                o_ctrl.reg_we    = 1'b1;
            end
            OPC_AUIPC: begin
                o_ctrl.a_sel_pc  = 1'b1;
                o_ctrl.b_sel_imm = 1'b1;
                o_ctrl.imm       = imm_u;
                o_ctrl.reg_we    = 1'b1;
            end
            default: ;
        endcase

        // nothing retires while the program is being loaded
        if (i_reset) begin
            o_ctrl.reg_we         = 1'b0;
            o_ctrl.mem_write_word = 1'b0;
            o_ctrl.mem_write_byte = 1'b0;
        end
    end

endmodule

// File: hw/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
    input  logic             clk,
    input  rv_pkg::reg_idx_t i_rs1,
    input  rv_pkg::reg_idx_t i_rs2,
    input  rv_pkg::reg_idx_t i_rd,
    input  logic             i_we,
    input  rv_pkg::word_t    i_wdata,
    output rv_pkg::word_t    o_rs1_data,
    output rv_pkg::word_t    o_rs2_data
);
    import rv_pkg::*;

    word_t regs [1:31];     // x0 is not stored

    always_ff @(posedge clk) begin
        if (i_we && i_rd != '0) begin
            regs[i_rd] <= i_wdata;
        end
    end

    assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

// File: hw/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
    input  rv_pkg::ctrl_t i_ctrl,
    input  rv_pkg::word_t i_rs1_data,
    input  rv_pkg::word_t i_rs2_data,
    input  rv_pkg::word_t i_pc,
    output rv_pkg::word_t o_result,
    output logic          o_branch_taken
);
    import rv_pkg::*;

    word_t      op_a;
    word_t      op_b;
    logic [4:0] shamt;

    assign op_a  = i_ctrl.a_sel_pc ? i_pc : i_rs1_data;     // auipc uses pc
    assign op_b  = i_ctrl.b_sel_imm ? i_ctrl.imm : i_rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (i_ctrl.alu_op)
            ALU_ADD:    o_result = op_a + op_b;
            ALU_SUB:    o_result = op_a - op_b;
            ALU_AND:    o_result = op_a & op_b;
            ALU_OR:     o_result = op_a | op_b;
            ALU_XOR:    o_result = op_a ^ op_b;
            ALU_SLL:    o_result = op_a << shamt;
            ALU_SRL:    o_result = op_a >> shamt;
            ALU_SRA:    o_result = word_t'($signed(op_a) >>> shamt);
            ALU_SLT:    o_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   o_result = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_PASS_B: o_result = op_b;
            default:    o_result = op_a + op_b;
        endcase
    end

    // branches always compare the two registers
    always_comb begin
        case (i_ctrl.branch_cond)
            BR_EQ:   o_branch_taken = (i_rs1_data == i_rs2_data);
            BR_NE:   o_branch_taken = (i_rs1_data != i_rs2_data);
            BR_LT:   o_branch_taken = ($signed(i_rs1_data) < $signed(i_rs2_data));
            BR_GE:   o_branch_taken = ($signed(i_rs1_data) >= $signed(i_rs2_data));
            BR_LTU:  o_branch_taken = (i_rs1_data < i_rs2_data);
            BR_GEU:  o_branch_taken = (i_rs1_data >= i_rs2_data);
            default: o_branch_taken = 1'b0;
        endcase
    end

endmodule

// File: hw/rv_lsu.sv
`timescale 1ns/1ps

module rv_lsu (
    input  rv_pkg::ctrl_t      i_ctrl,
    input  rv_pkg::word_t      i_addr_sum,
    input  rv_pkg::word_t      i_rs2_data,
    input  rv_pkg::word_t      i_pc_plus4,
    input  rv_pkg::word_t      i_rdata,
    output rv_pkg::mem_req_t   o_mem_req,
    output rv_pkg::word_t      o_wb_data,
    output logic               o_uart_valid,
    output rv_pkg::uart_byte_t o_uart_data
);
    import rv_pkg::*;

    logic [1:0] lane;
    logic       uart_hit;

    assign lane     = i_addr_sum[1:0];
    assign uart_hit = i_ctrl.mem_write_byte && (i_addr_sum == UART_TX_ADDR);

    // serial store strobes only, memory is left alone
    assign o_uart_valid = uart_hit;
    assign o_uart_data  = i_rs2_data[7:0];

    always_comb begin
        o_mem_req.idx = i_addr_sum[MEM_ADDR_W+1:2];
        o_mem_req.we  = (i_ctrl.mem_write_word || i_ctrl.mem_write_byte) && !uart_hit;
        if (i_ctrl.mem_write_byte) begin
            o_mem_req.be    = 4'b0001 << lane;
            o_mem_req.wdata = {4{i_rs2_data[7:0]}};   // byte on every lane
        end else begin
            o_mem_req.be    = 4'b1111;
            o_mem_req.wdata = i_rs2_data;
        end
    end

    always_comb begin
        if (i_ctrl.mem_read) begin
            o_wb_data = i_rdata;
        end else if (i_ctrl.link) begin
            o_wb_data = i_pc_plus4;     // jal / jalr return address
        end else begin
            o_wb_data = i_addr_sum;
        end
    end

endmodule

// File: hw/rv_memory.sv
`timescale 1ns/1ps

module rv_memory (
    input  logic               clk,
    input  logic               i_reset,
    input  rv_pkg::prog_load_t i_prog,
    input  rv_pkg::word_t      i_pc,
    output rv_pkg::word_t      o_instr,
    input  rv_pkg::mem_req_t   i_req,
    output rv_pkg::word_t      o_rdata
);
    import rv_pkg::*;

    word_t    mem [MEM_WORDS];
    mem_idx_t pc_idx;

    assign pc_idx = i_pc[MEM_ADDR_W+1:2];  // word aligned fetch

    always_ff @(posedge clk) begin
        if (i_reset) begin
            if (i_prog.en) begin
                mem[i_prog.idx] <= i_prog.data;
            end
        end else if (i_req.we) begin
            for (int b = 0; b < 4; b++) begin
                if (i_req.be[b]) begin
                    mem[i_req.idx][8*b +: 8] <= i_req.wdata[8*b +: 8];
                end
            end
        end
    end

    assign o_instr = mem[pc_idx];
    assign o_rdata = mem[i_req.idx];

endmodule

// File: hw/rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch (
    input  logic          clk,
    input  logic          reset,
    input  rv_pkg::ctrl_t i_ctrl,
    input  logic          i_branch_taken,
    input  rv_pkg::word_t i_rs1_data,
    output rv_pkg::word_t o_pc,
    output rv_pkg::word_t o_pc_plus4
);
    import rv_pkg::*;

    word_t pc_q;
    word_t pc_next;
    word_t rel_target;
    word_t jalr_target;

    assign o_pc        = pc_q;
    assign o_pc_plus4  = pc_q + 32'd4;
    assign rel_target  = pc_q + i_ctrl.imm;                     // branches and jal
    assign jalr_target = (i_rs1_data + i_ctrl.imm) & ~32'd1;    // bit 0 dropped

    always_comb begin
        case (i_ctrl.jump_kind)
            JMP_BRANCH: pc_next = i_branch_taken ? rel_target : o_pc_plus4;
            JMP_JAL:    pc_next = rel_target;
            JMP_JALR:   pc_next = jalr_target;
            default:    pc_next = o_pc_plus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= '0;
        end else begin
            pc_q <= pc_next;
        end
    end

endmodule

// File: hw/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top (
    input  logic               clk,
    input  logic               reset,
    input  rv_pkg::prog_load_t i_prog,
    output logic               o_uart_valid,
    output rv_pkg::uart_byte_t o_uart_data
);
    import rv_pkg::*;

    word_t    pc;
    word_t    pc_plus4;
    word_t    instr;
    ctrl_t    ctrl;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    alu_result;
    logic     branch_taken;
    mem_req_t mem_req;
    word_t    rdata;
    word_t    wb_data;

    rv_fetch i_rv_fetch (
        .clk            (clk),
        .reset          (reset),
        .i_ctrl         (ctrl),
        .i_branch_taken (branch_taken),
        .i_rs1_data     (rs1_data),
        .o_pc           (pc),
        .o_pc_plus4     (pc_plus4)
    );

    rv_memory i_rv_memory (
        .clk     (clk),
        .i_reset (reset),
        .i_prog  (i_prog),
        .i_pc    (pc),
        .o_instr (instr),
        .i_req   (mem_req),
        .o_rdata (rdata)
    );

    rv_decoder i_rv_decoder (
        .i_reset (reset),
        .i_instr (instr),
        .o_ctrl  (ctrl)
    );

    rv_regfile i_rv_regfile (
        .clk        (clk),
        .i_rs1      (ctrl.rs1),
        .i_rs2      (ctrl.rs2),
        .i_rd       (ctrl.rd),
        .i_we       (ctrl.reg_we),
        .i_wdata    (wb_data),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    rv_alu i_rv_alu (
        .i_ctrl         (ctrl),
        .i_rs1_data     (rs1_data),
        .i_rs2_data     (rs2_data),
        .i_pc           (pc),
        .o_result       (alu_result),
        .o_branch_taken (branch_taken)
    );

    rv_lsu i_rv_lsu (
        .i_ctrl       (ctrl),
        .i_addr_sum   (alu_result),
        .i_rs2_data   (rs2_data),
        .i_pc_plus4   (pc_plus4),
        .i_rdata      (rdata),
        .o_mem_req    (mem_req),
        .o_wb_data    (wb_data),
        .o_uart_valid (o_uart_valid),
        .o_uart_data  (o_uart_data)
    );

endmodule

// File: verif/rv_core_tb_model.svh
`ifndef RV_CORE_TB_MODEL_SVH
`define RV_CORE_TB_MODEL_SVH

// RV32I field layouts
function automatic word_t r_type(input logic [6:0] f7, input reg_idx_t rs2, input reg_idx_t rs1,
                                 input logic [2:0] f3, input reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic word_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                 input logic [2:0] f3, input reg_idx_t rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic word_t s_type(input logic [11:0] imm, input reg_idx_t rs2, input reg_idx_t rs1,
                                 input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
endfunction

function automatic word_t b_type(input logic [12:0] imm, input reg_idx_t rs2, input reg_idx_t rs1,
                                 input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
endfunction

function automatic word_t u_type(input logic [19:0] imm, input reg_idx_t rd,
                                 input logic [6:0] opc);
    return {imm, rd, opc};
endfunction

function automatic word_t j_type(input logic [20:0] imm, input reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
endfunction

// ISA semantics of the funct3 operations
function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                  input word_t a, input word_t b);
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b001:  return a << b[4:0];
        3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011:  return (a < b) ? 32'd1 : 32'd0;
        3'b100:  return a ^ b;
        3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branch_ref(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
        3'b000:  return a == b;
        3'b001:  return a != b;
        3'b100:  return $signed(a) < $signed(b);
        3'b101:  return $signed(a) >= $signed(b);
        3'b110:  return a < b;
        3'b111:  return a >= b;
        default: return 1'b0;
    endcase
endfunction

// runs a program until it jumps to itself and returns the serial bytes it sends
function automatic void run_reference(input word_t code [$], output uart_byte_t bytes [$]);
    word_t mem [MEM_WORDS];
    word_t x [32];
    word_t pc;
    word_t nxt;
    word_t ins;
    word_t imm_i;
    word_t addr;
    word_t res;
    logic  wr;
    int    step;
    bytes = {};
    foreach (mem[i]) mem[i] = '0;
    foreach (x[i]) x[i] = '0;
    foreach (code[i]) mem[i] = code[i];
    pc = '0;
    for (step = 0; step < 20000; step++) begin
        ins   = mem[pc[11:2]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        nxt   = pc + 32'd4;
        wr    = 1'b0;
        res   = '0;
        case (ins[6:0])
            OPC_OP: begin
                res = alu_ref(ins[14:12], ins[30], x[ins[19:15]], x[ins[24:20]]);
                wr  = 1'b1;
            end
            OPC_OP_IMM: begin
                res = alu_ref(ins[14:12], ins[14:12] == 3'b101 && ins[30], x[ins[19:15]], imm_i);
                wr  = 1'b1;
            end
            OPC_LUI: begin
                res = {ins[31:12], 12'h000};
                wr  = 1'b1;
            end
            OPC_AUIPC: begin
                res = pc + {ins[31:12], 12'h000};
                wr  = 1'b1;
            end
            OPC_JAL: begin
                res = pc + 32'd4;
                nxt = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                wr  = 1'b1;
            end
            OPC_JALR: begin
                res = pc + 32'd4;
                nxt = (x[ins[19:15]] + imm_i) & ~32'd1;
                wr  = 1'b1;
            end
            OPC_BRANCH: begin
                if (branch_ref(ins[14:12], x[ins[19:15]], x[ins[24:20]])) begin
                    nxt = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            OPC_LOAD: begin
                if (ins[14:12] == 3'b010) begin
                    addr = x[ins[19:15]] + imm_i;
                    res  = mem[addr[11:2]];
                    wr   = 1'b1;
                end
            end
            OPC_STORE: begin
                addr = x[ins[19:15]] + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                if (ins[14:12] == 3'b000) begin
                    if (addr == UART_TX_ADDR) begin
                        bytes.push_back(x[ins[24:20]][7:0]);   // serial only, no memory write
                    end else begin
                        mem[addr[11:2]][8*addr[1:0] +: 8] = x[ins[24:20]][7:0];
                    end
                end else if (ins[14:12] == 3'b010) begin
                    mem[addr[11:2]] = x[ins[24:20]];
                end
            end
            default: ;
        endcase
        if (wr && ins[11:7] != 5'd0) begin
            x[ins[11:7]] = res;
        end
        if (nxt == pc) begin
            break;      // final self loop
        end
        pc = nxt;
    end
endfunction

`endif

// File: verif/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;
    import rv_pkg::*;

    `include "rv_core_tb_model.svh"

    logic       clk;
    logic       reset;
    prog_load_t prog_in;
    logic       uart_valid;
    uart_byte_t uart_data;

    word_t      prog [$];       // program being built
    uart_byte_t exp_bytes [$];
    int         got_count;

    rv_core_top i_rv_core_top (
        .clk          (clk),
        .reset        (reset),
        .i_prog       (prog_in),
        .o_uart_valid (uart_valid),
        .o_uart_data  (uart_data)
    );

    always #50 clk = ~clk;

    task automatic abort_run();
        $display("Errors found");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_uart_byte(input uart_byte_t got, input uart_byte_t exp, input int n);
        if (got !== exp) begin
            $display("Error at %0t ns: serial byte %0d was 0x%02h, expected 0x%02h",
                     $time, n, got, exp);
            abort_run();
        end
    endtask

    // sampled mid cycle while the executing instruction is stable
    always @(negedge clk) begin
        if (uart_valid) begin
            if (reset) begin
                $display("A serial strobe appeared while reset was held.");
                abort_run();
            end else if (got_count >= exp_bytes.size()) begin
                $display("A serial strobe appeared after all expected bytes had arrived.");
                abort_run();
            end else begin
                check_uart_byte(uart_data, exp_bytes[got_count], got_count);
                got_count++;
            end
        end
    end

    task automatic emit(input word_t w);
        prog.push_back(w);
    endtask

    task automatic load_const(input reg_idx_t rd, input word_t v);
        word_t upper;
        upper = v + 32'h800;        // addi sign-extends the low part
        emit(u_type(upper[31:12], rd, OPC_LUI));
        emit(i_type(v[11:0], rd, 3'b000, rd, OPC_OP_IMM));
    endtask

    // x30 is scratch, x31 holds the serial base
    task automatic send_reg(input reg_idx_t rs);
        emit(i_type(12'h000, rs, 3'b000, 5'd30, OPC_OP_IMM));
        for (int k = 0; k < 4; k++) begin
            emit(s_type(12'h020, 5'd30, 5'd31, 3'b000));
            if (k < 3) begin
                emit(i_type(12'd8, 5'd30, 3'b101, 5'd30, OPC_OP_IMM));   // srli 8
            end
        end
    endtask

    task automatic open_program();
        prog = {};
        emit(u_type(20'h00020, 5'd31, OPC_LUI));
    endtask

    task automatic alu_program();
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        open_program();
        for (int k = 0; k < 10; k++) begin
            f3  = (k < 8) ? 3'(k) : ((k == 8) ? 3'b000 : 3'b101);   // then sub and sra
            alt = (k >= 8);
            load_const(5'd1, $urandom());
            load_const(5'd2, $urandom());
            emit(r_type(alt ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, 5'd3));
            send_reg(5'd3);
            if (k != 8) begin
                imm = 12'($urandom());
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    imm = {alt ? 7'h20 : 7'h00, imm[4:0]};
                end
                emit(i_type(imm, 5'd1, f3, 5'd4, OPC_OP_IMM));
                send_reg(5'd4);
            end
        end
    endtask

    task automatic upper_program();
        open_program();
        emit(i_type(12'($urandom()), 5'd0, 3'b000, 5'd0, OPC_OP_IMM));
        emit(u_type(20'($urandom()), 5'd0, OPC_LUI));
        send_reg(5'd0);
        emit(u_type(20'($urandom()), 5'd5, OPC_LUI));
        send_reg(5'd5);
        emit(u_type(20'($urandom()), 5'd6, OPC_AUIPC));
        send_reg(5'd6);
    endtask

    task automatic branch_program();
        word_t a;
        word_t b;
        word_t target;
        open_program();
        for (int k = 0; k < 12; k++) begin
            a = $urandom();
            b = ($urandom() % 4 == 0) ? a : $urandom();
            load_const(5'd1, a);
            load_const(5'd2, b);
            emit(b_type(13'd12, 5'd2, 5'd1, 3'((k % 6 < 2) ? k % 6 : k % 6 + 2)));
            emit(i_type(12'(16 + k), 5'd0, 3'b000, 5'd29, OPC_OP_IMM));   // not taken
            emit(j_type(21'd8, 5'd0));
            emit(i_type(12'(64 + k), 5'd0, 3'b000, 5'd29, OPC_OP_IMM));   // taken
            emit(s_type(12'h020, 5'd29, 5'd31, 3'b000));
        end
        emit(j_type(21'd8, 5'd7));
        emit(s_type(12'h020, 5'd0, 5'd31, 3'b000));     // skipped by jal
        send_reg(5'd7);
        target = word_t'((prog.size() + 4) * 4);
        load_const(5'd8, target | 32'd1);               // odd, jalr drops bit 0
        emit(i_type(12'h000, 5'd8, 3'b000, 5'd9, OPC_JALR));
        emit(s_type(12'h020, 5'd0, 5'd31, 3'b000));     // skipped by jalr
        send_reg(5'd9);
        emit(u_type(20'h00000, 5'd10, OPC_AUIPC));      // shows the pc after jalr
        send_reg(5'd10);
    endtask

    task automatic memory_program();
        word_t addr;
        int    lane;
        open_program();
        addr = word_t'((768 + $urandom() % 256) * 4);     // well above the code
        lane = $urandom() % 4;
        load_const(5'd10, addr);
        load_const(5'd11, $urandom());
        emit(s_type(12'h000, 5'd11, 5'd10, 3'b010));
        emit(i_type(12'h000, 5'd10, 3'b010, 5'd12, OPC_LOAD));
        send_reg(5'd12);
        load_const(5'd13, $urandom());
        emit(s_type(12'(lane), 5'd13, 5'd10, 3'b000));
        emit(i_type(12'h000, 5'd10, 3'b010, 5'd14, OPC_LOAD));
        send_reg(5'd14);
    endtask

    task automatic run_program(input string name);
        int n;
        int cycles;
        emit(j_type(21'd0, 5'd0));      // park in a self loop
        run_reference(prog, exp_bytes);
        got_count = 0;
        @(posedge clk);
        #1;
        reset        = 1'b1;
        prog_in      = '0;
        prog_in.en   = 1'b1;
        prog_in.data = s_type(12'h020, 5'd31, 5'd31, 3'b000);   // serial sb at word 0
        @(posedge clk);
        #1;
        n = (prog.size() > 4) ? prog.size() : 4;
        for (int i = 0; i < n; i++) begin
            prog_in = '0;
            if (i < prog.size()) begin
                prog_in.en   = 1'b1;
                prog_in.idx  = mem_idx_t'(i);
                prog_in.data = prog[i];
            end
            @(posedge clk);
            #1;
        end
        prog_in = '0;
        reset   = 1'b0;
        cycles  = 0;
        while (got_count < exp_bytes.size() && cycles < 4000) begin
            @(posedge clk);
            cycles++;
        end
        if (got_count < exp_bytes.size()) begin
            $display("%s test: serial byte %0d of %0d never came", name, got_count,
                     exp_bytes.size());
            abort_run();
        end
        repeat (50) @(posedge clk);     // extra strobes are caught by the checker
    endtask

    initial begin
        void'($urandom(91));
        clk       = 1'b0;
        reset     = 1'b1;
        prog_in   = '0;
        got_count = 0;
        repeat (2) begin
            alu_program();
            run_program("alu");
        end
        upper_program();
        run_program("upper immediate");
        repeat (2) begin
            branch_program();
            run_program("branch and jump");
        end
        repeat (2) begin
            memory_program();
            run_program("memory");
        end
        $display("No errors");
        $finish;
    end

endmodule

// File: sim.f
+incdir+verif
hw/rv_pkg.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_lsu.sv
hw/rv_memory.sv
hw/rv_fetch.sv
hw/rv_core_top.sv
verif/rv_core_tb.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - files:
      - hw/rv_pkg.sv
      - hw/rv_decoder.sv
      - hw/rv_regfile.sv
      - hw/rv_alu.sv
      - hw/rv_lsu.sv
      - hw/rv_memory.sv
      - hw/rv_fetch.sv
      - hw/rv_core_top.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/rv_core_tb.sv
